// ==== hw/cam_pkg.sv ====
package cam_pkg;

  // column counter and per-region counter widths
  localparam int COL_W = 10;
  localparam int CNT_W = 19;

  // active pixels per line
  localparam logic [COL_W-1:0] LINE_WIDTH = 10'd640;
  // first column of the centre third
  localparam logic [COL_W-1:0] LEFT_EDGE  = 10'd213;
  // first column of the right third
  localparam logic [COL_W-1:0] RIGHT_EDGE = 10'd427;

  // orange window on the expanded 8-bit channels
  localparam logic [7:0] ORANGE_R_MIN = 8'd192;
  localparam logic [7:0] ORANGE_G_MIN = 8'd64;
  localparam logic [7:0] ORANGE_G_MAX = 8'd176;
  localparam logic [7:0] ORANGE_B_MAX = 8'd96;

  // marker colour painted over orange pixels, pure green
  localparam logic [7:0] MARK_R = 8'd0;
  localparam logic [7:0] MARK_G = 8'd255;
  localparam logic [7:0] MARK_B = 8'd0;

  // fewest orange pixels per frame before a direction is reported
  localparam logic [CNT_W-1:0] MIN_HITS = 19'd16;

  typedef enum logic [1:0] {
    DIR_NONE,
    DIR_LEFT,
    DIR_CENTER,
    DIR_RIGHT
  } direction_e;

  // remote opcodes from the IR decoder
  typedef enum logic [2:0] {
    CMD_STOP,
    CMD_FORWARD,
    CMD_LEFT,
    CMD_RIGHT,
    CMD_AUTO
  } ir_cmd_e;

  typedef enum logic [1:0] {
    DRV_STOP,
    DRV_FWD,
    DRV_LEFT,
    DRV_RIGHT
  } drive_state_e;

  typedef enum logic {
    MODE_MANUAL,
    MODE_AUTO
  } mode_e;

  // frame buffer read-out, data is RGB444 with red in the top nibble
  typedef struct packed {
    logic        active;
    logic        hsync;
    logic        vsync;
    logic [11:0] data;
  } pixel_in_t;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb_t;

  typedef struct packed {
    logic active;
    logic hsync;
    logic vsync;
    rgb_t rgb;
  } pixel_out_t;

  typedef struct packed {
    drive_state_e state;
    logic [1:0]   speed;
  } drive_cmd_t;

endpackage

// ==== hw/pixel_unpack.sv ====
`timescale 1ns/1ps

module pixel_unpack (
  input  logic                clk_25_vga,
  input  logic                arst_n,
  input  cam_pkg::pixel_in_t  pix_in,
  output cam_pkg::pixel_out_t pix_out
);

  // expanded colour before the output register
  cam_pkg::rgb_t rgb_exp;

  // nibble repeated into both halves, so 4'hf maps to 8'hff and 4'h0 to 8'h00
  // outside the visible area the colour is forced to black
  always_comb begin
    if (pix_in.active) begin
      rgb_exp.r = {pix_in.data[11:8], pix_in.data[11:8]};
      rgb_exp.g = {pix_in.data[7:4], pix_in.data[7:4]};
      rgb_exp.b = {pix_in.data[3:0], pix_in.data[3:0]};
    end else begin
      rgb_exp.r = 8'h00;
      rgb_exp.g = 8'h00;
      rgb_exp.b = 8'h00;
    end
  end

  // one stage register, strobes ride along with the colour
  // black and idle out of reset so the overlay shows nothing stale
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      pix_out.active <= 1'b0;
      pix_out.hsync  <= 1'b0;
      pix_out.vsync  <= 1'b0;
      pix_out.rgb    <= '0;
    end else begin
      pix_out.active <= pix_in.active;
      pix_out.hsync  <= pix_in.hsync;
      pix_out.vsync  <= pix_in.vsync;
      pix_out.rgb    <= rgb_exp;
    end
  end

endmodule

// ==== hw/target_finder.sv ====
`timescale 1ns/1ps

module target_finder (
  input  logic                clk_25_vga,
  input  logic                arst_n,
  input  cam_pkg::pixel_out_t pix_in,
  output cam_pkg::pixel_out_t pix_out,
  output logic                hit
);

  // per-channel window checks
  logic r_ok;
  logic g_ok;
  logic b_ok;
  // red must dominate green, otherwise yellows slip through
  logic r_over_g;
  logic is_orange;

  // colour leaving this stage
  cam_pkg::rgb_t rgb_next;

  assign r_ok     = (pix_in.rgb.r >= cam_pkg::ORANGE_R_MIN);
  assign g_ok     = (pix_in.rgb.g >= cam_pkg::ORANGE_G_MIN) &&
                    (pix_in.rgb.g <= cam_pkg::ORANGE_G_MAX);
  assign b_ok     = (pix_in.rgb.b <= cam_pkg::ORANGE_B_MAX);
  assign r_over_g = (pix_in.rgb.r > pix_in.rgb.g);

  // blanked pixels never count, even if the colour fields were garbage
  assign is_orange = pix_in.active && r_ok && g_ok && b_ok && r_over_g;

  // overlay so the VGA output shows exactly what the tracker locked onto
  always_comb begin
    if (is_orange) begin
      rgb_next.r = cam_pkg::MARK_R;
      rgb_next.g = cam_pkg::MARK_G;
      rgb_next.b = cam_pkg::MARK_B;
    end else begin
      rgb_next = pix_in.rgb;
    end
  end

  // hit is registered with its pixel so the classifier sees them aligned
  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      pix_out.active <= 1'b0;
      pix_out.hsync  <= 1'b0;
      pix_out.vsync  <= 1'b0;
      pix_out.rgb    <= '0;
      hit            <= 1'b0;
    end else begin
      pix_out.active <= pix_in.active;
      pix_out.hsync  <= pix_in.hsync;
      pix_out.vsync  <= pix_in.vsync;
      pix_out.rgb    <= rgb_next;
      hit            <= is_orange;
    end
  end

endmodule

// ==== hw/direction_classifier.sv ====
`timescale 1ns/1ps

module direction_classifier (
  input  logic                clk_25_vga,
  input  logic                arst_n,
  input  cam_pkg::pixel_out_t pix_in,
  input  logic                hit,
  output cam_pkg::direction_e direction,
  output logic                dir_valid
);

  // column of the current pixel within its line
  logic [cam_pkg::COL_W-1:0] col;

  // orange pixel counts for the frame so far
  logic [cam_pkg::CNT_W-1:0] cnt_left;
  logic [cam_pkg::CNT_W-1:0] cnt_center;
  logic [cam_pkg::CNT_W-1:0] cnt_right;

  // region of the current hit
  logic hit_left;
  logic hit_center;
  logic hit_right;

  // counts including the current pixel
  logic [cam_pkg::CNT_W-1:0] sum_left;
  logic [cam_pkg::CNT_W-1:0] sum_center;
  logic [cam_pkg::CNT_W-1:0] sum_right;
  // two extra bits so the three-way sum cannot wrap
  logic [cam_pkg::CNT_W+1:0] total;

  cam_pkg::direction_e dir_next;

  // thirds split by column, checked left to right
  always_comb begin
    hit_left   = 1'b0;
    hit_center = 1'b0;
    hit_right  = 1'b0;
    if (hit && pix_in.active) begin
      if (col < cam_pkg::LEFT_EDGE) begin
        hit_left = 1'b1;
      end else if (col < cam_pkg::RIGHT_EDGE) begin
        hit_center = 1'b1;
      end else begin
        hit_right = 1'b1;
      end
    end
  end

  assign sum_left   = cnt_left + {{(cam_pkg::CNT_W-1){1'b0}}, hit_left};
  assign sum_center = cnt_center + {{(cam_pkg::CNT_W-1){1'b0}}, hit_center};
  assign sum_right  = cnt_right + {{(cam_pkg::CNT_W-1){1'b0}}, hit_right};

  assign total = {2'b00, sum_left} + {2'b00, sum_center} + {2'b00, sum_right};

  // too few hits means no target
  // otherwise largest third wins, ties favour centre then left
  always_comb begin
    if (total < {2'b00, cam_pkg::MIN_HITS}) begin
      dir_next = cam_pkg::DIR_NONE;
    end else if ((sum_center >= sum_left) && (sum_center >= sum_right)) begin
      dir_next = cam_pkg::DIR_CENTER;
    end else if (sum_left >= sum_right) begin
      dir_next = cam_pkg::DIR_LEFT;
    end else begin
      dir_next = cam_pkg::DIR_RIGHT;
    end
  end

  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      col        <= '0;
      cnt_left   <= '0;
      cnt_center <= '0;
      cnt_right  <= '0;
      direction  <= cam_pkg::DIR_NONE;
      dir_valid  <= 1'b0;
    end else begin
      // vsync is a single-cycle pulse, so the strobe is too
      dir_valid <= pix_in.vsync;
      // column holds at LINE_WIDTH if a line runs long
      if (pix_in.hsync) begin
        col <= '0;
      end else if (pix_in.active && (col != cam_pkg::LINE_WIDTH)) begin
        col <= col + 1'b1;
      end
      if (pix_in.vsync) begin
        // decide and start the next frame from zero
        direction  <= dir_next;
        cnt_left   <= '0;
        cnt_center <= '0;
        cnt_right  <= '0;
      end else begin
        cnt_left   <= sum_left;
        cnt_center <= sum_center;
        cnt_right  <= sum_right;
      end
    end
  end

endmodule

// ==== hw/drive_fsm.sv ====
`timescale 1ns/1ps

module drive_fsm (
  input  logic                clk_25_vga,
  input  logic                arst_n,
  input  logic                ir_valid,
  input  cam_pkg::ir_cmd_e    ir_cmd,
  input  cam_pkg::direction_e direction,
  input  logic                dir_valid,
  input  logic [1:0]          speed,
  output cam_pkg::drive_cmd_t drive
);

  cam_pkg::mode_e        mode;
  cam_pkg::drive_state_e state;
  cam_pkg::mode_e        mode_next;
  cam_pkg::drive_state_e state_next;

  always_comb begin
    mode_next  = mode;
    state_next = state;
    if (ir_valid) begin
      // remote always wins over the camera, any motion command drops to manual
      case (ir_cmd)
        cam_pkg::CMD_STOP: begin
          mode_next  = cam_pkg::MODE_MANUAL;
          state_next = cam_pkg::DRV_STOP;
        end
        cam_pkg::CMD_FORWARD: begin
          mode_next  = cam_pkg::MODE_MANUAL;
          state_next = cam_pkg::DRV_FWD;
        end
        cam_pkg::CMD_LEFT: begin
          mode_next  = cam_pkg::MODE_MANUAL;
          state_next = cam_pkg::DRV_LEFT;
        end
        cam_pkg::CMD_RIGHT: begin
          mode_next  = cam_pkg::MODE_MANUAL;
          state_next = cam_pkg::DRV_RIGHT;
        end
        // hand over to the camera, keep moving as before until the next frame
        cam_pkg::CMD_AUTO: begin
          mode_next = cam_pkg::MODE_AUTO;
        end
        // unknown opcodes are dropped
        default: begin
          mode_next = mode;
        end
      endcase
    end else if (dir_valid && (mode == cam_pkg::MODE_AUTO)) begin
      // follow the target, lost target means stop
      case (direction)
        cam_pkg::DIR_LEFT:   state_next = cam_pkg::DRV_LEFT;
        cam_pkg::DIR_CENTER: state_next = cam_pkg::DRV_FWD;
        cam_pkg::DIR_RIGHT:  state_next = cam_pkg::DRV_RIGHT;
        default:             state_next = cam_pkg::DRV_STOP;
      endcase
    end
  end

  always_ff @(posedge clk_25_vga or negedge arst_n) begin
    if (!arst_n) begin
      mode  <= cam_pkg::MODE_MANUAL;
      state <= cam_pkg::DRV_STOP;
    end else begin
      mode  <= mode_next;
      state <= state_next;
    end
  end

  // motor speed follows the level input, but never while stopped
  assign drive.state = state;
  assign drive.speed = (state == cam_pkg::DRV_STOP) ? 2'b00 : speed;

endmodule

// ==== hw/cam_track_top.sv ====
`timescale 1ns/1ps

module cam_track_top (
  input  logic                clk_25_vga,
  input  logic                arst_n,
  input  cam_pkg::pixel_in_t  pix_in,
  input  logic                ir_valid,
  input  cam_pkg::ir_cmd_e    ir_cmd,
  input  logic [1:0]          speed,
  output cam_pkg::pixel_out_t pix_out,
  output cam_pkg::direction_e direction,
  output logic                dir_valid,
  output cam_pkg::drive_cmd_t drive
);

  // decode to execute
  cam_pkg::pixel_out_t unpacked_pix;
  // orange flag, aligned with pix_out
  logic                hit;

  // RGB444 to RGB888 with blanking, 1 cycle
  pixel_unpack u_pixel_unpack (
    .clk_25_vga (clk_25_vga),
    .arst_n     (arst_n),
    .pix_in     (pix_in),
    .pix_out    (unpacked_pix)
  );

  // orange test and marker overlay, 1 cycle
  // its output is also the pixel stream seen by the classifier
  target_finder u_target_finder (
    .clk_25_vga (clk_25_vga),
    .arst_n     (arst_n),
    .pix_in     (unpacked_pix),
    .pix_out    (pix_out),
    .hit        (hit)
  );

  // per-frame region counts, decision one cycle after the delayed vsync
  direction_classifier u_direction_classifier (
    .clk_25_vga (clk_25_vga),
    .arst_n     (arst_n),
    .pix_in     (pix_out),
    .hit        (hit),
    .direction  (direction),
    .dir_valid  (dir_valid)
  );

  // IR remote and camera direction to motor command
  drive_fsm u_drive_fsm (
    .clk_25_vga (clk_25_vga),
    .arst_n     (arst_n),
    .ir_valid   (ir_valid),
    .ir_cmd     (ir_cmd),
    .direction  (direction),
    .dir_valid  (dir_valid),
    .speed      (speed),
    .drive      (drive)
  );

endmodule

// ==== dv/cam_track_assertions.sv ====
`timescale 1ns/1ps

module cam_track_assertions (
  input logic                clk_25_vga,
  input logic                arst_n,
  input cam_pkg::pixel_in_t  pix_in,
  input cam_pkg::pixel_out_t pix_out,
  input logic                dir_valid,
  input cam_pkg::drive_cmd_t drive
);

  // decision strobe is a single-cycle pulse
  dir_valid_pulse: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
    dir_valid |=> !dir_valid)
    else $error("dir_valid stayed high for two cycles");

  // strobe rises only 3 cycles after a vsync at the input
  dir_valid_after_vsync: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
    $rose(dir_valid) |-> $past(pix_in.vsync, 3))
    else $error("dir_valid rose without a vsync 3 cycles earlier");

  // and every input vsync produces it
  vsync_gives_dir_valid: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
    $past(pix_in.vsync, 3) |-> dir_valid)
    else $error("vsync 3 cycles ago gave no dir_valid");

  // stopped means no motor speed
  stop_has_no_speed: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
    (drive.state == cam_pkg::DRV_STOP) |-> (drive.speed == 2'b00))
    else $error("drive speed nonzero while stopped");

  // blanking reaches the output
  blank_is_black: assert property (@(posedge clk_25_vga) disable iff (!arst_n)
    !pix_out.active |-> (pix_out.rgb == '0))
    else $error("pix_out colour nonzero outside the active area");

endmodule

bind cam_track_top cam_track_assertions cam_track_assertions_i (
  .clk_25_vga (clk_25_vga),
  .arst_n     (arst_n),
  .pix_in     (pix_in),
  .pix_out    (pix_out),
  .dir_valid  (dir_valid),
  .drive      (drive)
);

// ==== dv/cam_track_tb.sv ====
`timescale 1ns/1ps

module cam_track_tb;

  // about 16 frames of 4 lines at ~2600 cycles each, with headroom
  localparam int TIMEOUT_CYCLES = 60000;

  logic                clk_25_vga;
  logic                arst_n;
  cam_pkg::pixel_in_t  pix_in;
  logic                ir_valid;
  cam_pkg::ir_cmd_e    ir_cmd;
  logic [1:0]          speed;
  cam_pkg::pixel_out_t pix_out;
  cam_pkg::direction_e direction;
  logic                dir_valid;
  cam_pkg::drive_cmd_t drive;

  logic [31:0]         rng;
  int                  cycles = 0;
  // expected pix_out one and two cycles ahead
  cam_pkg::pixel_out_t exp_d1 = '0;
  cam_pkg::pixel_out_t exp_d2 = '0;
  // input vsync over the last three cycles
  logic [2:0]          vs_hist = '0;
  // threshold probes
  // first three orange, next four just past one limit each, last has r equal to g
  logic [11:0]         probe [8] = '{12'hC40, 12'hFA5, 12'hE80, 12'hB40,
                                     12'hC30, 12'hCB0, 12'hC46, 12'hCC0};

  cam_track_top cam_track_top_i (
    .clk_25_vga (clk_25_vga),
    .arst_n     (arst_n),
    .pix_in     (pix_in),
    .ir_valid   (ir_valid),
    .ir_cmd     (ir_cmd),
    .speed      (speed),
    .pix_out    (pix_out),
    .direction  (direction),
    .dir_valid  (dir_valid),
    .drive      (drive)
  );

  always #10 clk_25_vga = ~clk_25_vga;

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge clk_25_vga) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      stop_with_error($sformatf("timeout after %0d cycles, tests did not finish", cycles));
    end
  end

  task automatic step();
    @(posedge clk_25_vga);
    #2;
  endtask

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  function automatic cam_pkg::drive_cmd_t drive_of(input cam_pkg::drive_state_e st,
                                                   input logic [1:0] spd);
    cam_pkg::drive_cmd_t d;
    d.state = st;
    d.speed = spd;
    return d;
  endfunction

  // nibble doubled, black when blanked, then orange pixels become the marker
  function automatic cam_pkg::pixel_out_t expect_pixel(input cam_pkg::pixel_in_t p);
    cam_pkg::pixel_out_t o;
    o.active = p.active;
    o.hsync  = p.hsync;
    o.vsync  = p.vsync;
    o.rgb    = '0;
    if (p.active) begin
      o.rgb.r = {p.data[11:8], p.data[11:8]};
      o.rgb.g = {p.data[7:4], p.data[7:4]};
      o.rgb.b = {p.data[3:0], p.data[3:0]};
    end
    if (p.active && (o.rgb.r >= cam_pkg::ORANGE_R_MIN) && (o.rgb.g >= cam_pkg::ORANGE_G_MIN) &&
        (o.rgb.g <= cam_pkg::ORANGE_G_MAX) && (o.rgb.b <= cam_pkg::ORANGE_B_MAX) &&
        (o.rgb.r > o.rgb.g)) begin
      o.rgb.r = cam_pkg::MARK_R;
      o.rgb.g = cam_pkg::MARK_G;
      o.rgb.b = cam_pkg::MARK_B;
    end
    return o;
  endfunction

  task automatic check_pixel(input cam_pkg::pixel_out_t got, input cam_pkg::pixel_out_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch at %0t: pix_out got %h expected %h", $time, got, exp));
    end
  endtask

  task automatic check_direction(input cam_pkg::direction_e got,
                                 input cam_pkg::direction_e exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch at %0t: direction got %s expected %s",
                                $time, got.name(), exp.name()));
    end
  endtask

  task automatic check_drive(input cam_pkg::drive_cmd_t got, input cam_pkg::drive_cmd_t exp);
    if (got !== exp) begin
      stop_with_error($sformatf("Mismatch at %0t: drive got %h expected %h", $time, got, exp));
    end
  endtask

  // pix_out sampled mid-cycle against the model two cycles back
  always @(negedge clk_25_vga) begin
    if (arst_n) begin
      check_pixel(pix_out, exp_d2);
      if (dir_valid !== vs_hist[2]) begin
        stop_with_error($sformatf("Mismatch at %0t: dir_valid got %b expected %b",
                                  $time, dir_valid, vs_hist[2]));
      end
    end
    exp_d2  = exp_d1;
    exp_d1  = expect_pixel(pix_in);
    vs_hist = {vs_hist[1:0], pix_in.vsync};
  end

  // kind 0 orange band, kind 1 random non-orange, kind 2 threshold probes in the band
  function automatic logic [11:0] colour_at(input int kind, input int col, input bit in_rng);
    logic [31:0] r;
    logic [11:0] c;
    r = next_rand();
    if (kind == 1) begin
      // red nibble capped at B keeps r below ORANGE_R_MIN
      c = r[11:0] & 12'hBFF;
    end else if (!in_rng) begin
      c = 12'h248;
    end else if (kind == 2) begin
      c = probe[col[2:0]];
    end else begin
      c = 12'hE80;
    end
    return c;
  endfunction

  task automatic send_line(input int kind, input int lo, input int hi);
    int          col;
    logic [31:0] r;
    pix_in       = '0;
    pix_in.hsync = 1'b1;
    step();
    for (col = 0; col < int'(cam_pkg::LINE_WIDTH); col = col + 1) begin
      pix_in        = '0;
      pix_in.active = 1'b1;
      pix_in.data   = colour_at(kind, col, (col >= lo) && (col < hi));
      step();
      r = next_rand();
      if ((kind == 1) && (r[2:0] == 3'd0)) begin
        // blanked gap with live data that must not leak through
        pix_in.active = 1'b0;
        pix_in.data   = r[27:16];
        step();
      end
    end
    pix_in = '0;
    repeat (4) step();
  endtask

  task automatic send_vsync();
    pix_in       = '0;
    pix_in.vsync = 1'b1;
    step();
    pix_in = '0;
  endtask

  task automatic send_ir(input cam_pkg::ir_cmd_e cmd);
    ir_valid = 1'b1;
    ir_cmd   = cmd;
    step();
    ir_valid = 1'b0;
  endtask

  // line 0 uses band a, lines 1 to 3 band b; optional IR command alongside dir_valid
  task automatic run_frame(input int kind, input int lo_a, input int hi_a, input int lo_b,
                           input int hi_b, input cam_pkg::direction_e exp_dir,
                           input bit with_ir, input cam_pkg::ir_cmd_e cmd);
    int waited;
    send_line(kind, lo_a, hi_a);
    repeat (3) send_line(kind, lo_b, hi_b);
    send_vsync();
    waited = 1;
    while (!dir_valid) begin
      if (waited >= 3) begin
        stop_with_error("dir_valid did not arrive 3 cycles after vsync");
      end else begin
        step();
        waited = waited + 1;
      end
    end
    check_direction(direction, exp_dir);
    if (with_ir) begin
      send_ir(cmd);
    end else begin
      step();
    end
  endtask

  task automatic pixel_path_test();
    run_frame(1, 0, 0, 0, 0, cam_pkg::DIR_NONE, 1'b0, cam_pkg::CMD_STOP);
  endtask

  // probes repeat every 8 columns, left and centre both get 81 hits, right 78
  task automatic threshold_test();
    run_frame(2, 0, 640, 0, 0, cam_pkg::DIR_CENTER, 1'b0, cam_pkg::CMD_STOP);
  endtask

  task automatic direction_test();
    run_frame(0, 100, 300, 100, 300, cam_pkg::DIR_LEFT, 1'b0, cam_pkg::CMD_STOP);
    run_frame(0, 200, 450, 200, 450, cam_pkg::DIR_CENTER, 1'b0, cam_pkg::CMD_STOP);
    run_frame(0, 400, 640, 400, 640, cam_pkg::DIR_RIGHT, 1'b0, cam_pkg::CMD_STOP);
  endtask

  task automatic min_hits_tie_test();
    // 15 hits right after a busy frame, so the counts must have cleared
    run_frame(0, 0, 15, 0, 0, cam_pkg::DIR_NONE, 1'b0, cam_pkg::CMD_STOP);
    run_frame(0, 0, 16, 0, 0, cam_pkg::DIR_LEFT, 1'b0, cam_pkg::CMD_STOP);
    // 13 left and 13 centre
    run_frame(0, 200, 226, 0, 0, cam_pkg::DIR_CENTER, 1'b0, cam_pkg::CMD_STOP);
    // 30 left and 3 x 10 right
    run_frame(0, 0, 30, 630, 640, cam_pkg::DIR_LEFT, 1'b0, cam_pkg::CMD_STOP);
  endtask

  task automatic manual_drive_test();
    speed = 2'd2;
    send_ir(cam_pkg::CMD_FORWARD);
    check_drive(drive, drive_of(cam_pkg::DRV_FWD, 2'd2));
    speed = 2'd3;
    send_ir(cam_pkg::CMD_LEFT);
    check_drive(drive, drive_of(cam_pkg::DRV_LEFT, 2'd3));
    speed = 2'd1;
    send_ir(cam_pkg::CMD_RIGHT);
    check_drive(drive, drive_of(cam_pkg::DRV_RIGHT, 2'd1));
    send_ir(cam_pkg::CMD_STOP);
    check_drive(drive, drive_of(cam_pkg::DRV_STOP, 2'd0));
    send_ir(cam_pkg::CMD_FORWARD);
    // camera says left, manual mode keeps going forward
    run_frame(0, 100, 300, 100, 300, cam_pkg::DIR_LEFT, 1'b0, cam_pkg::CMD_STOP);
    check_drive(drive, drive_of(cam_pkg::DRV_FWD, 2'd1));
  endtask

  task automatic auto_drive_test();
    send_ir(cam_pkg::CMD_AUTO);
    check_drive(drive, drive_of(cam_pkg::DRV_FWD, 2'd1));
    run_frame(0, 100, 300, 100, 300, cam_pkg::DIR_LEFT, 1'b0, cam_pkg::CMD_STOP);
    check_drive(drive, drive_of(cam_pkg::DRV_LEFT, 2'd1));
    run_frame(0, 400, 640, 400, 640, cam_pkg::DIR_RIGHT, 1'b0, cam_pkg::CMD_STOP);
    check_drive(drive, drive_of(cam_pkg::DRV_RIGHT, 2'd1));
    run_frame(0, 0, 15, 0, 0, cam_pkg::DIR_NONE, 1'b0, cam_pkg::CMD_STOP);
    check_drive(drive, drive_of(cam_pkg::DRV_STOP, 2'd0));
    run_frame(0, 200, 450, 200, 450, cam_pkg::DIR_CENTER, 1'b0, cam_pkg::CMD_STOP);
    check_drive(drive, drive_of(cam_pkg::DRV_FWD, 2'd1));
    // IR left lands with a right decision, remote wins and mode drops to manual
    run_frame(0, 400, 640, 400, 640, cam_pkg::DIR_RIGHT, 1'b1, cam_pkg::CMD_LEFT);
    check_drive(drive, drive_of(cam_pkg::DRV_LEFT, 2'd1));
    run_frame(0, 200, 450, 200, 450, cam_pkg::DIR_CENTER, 1'b0, cam_pkg::CMD_STOP);
    check_drive(drive, drive_of(cam_pkg::DRV_LEFT, 2'd1));
  endtask

  initial begin
    clk_25_vga = 1'b0;
    arst_n     = 1'b0;
    pix_in     = '0;
    ir_valid   = 1'b0;
    ir_cmd     = cam_pkg::CMD_STOP;
    speed      = 2'd0;
    rng        = 32'd59609;
    repeat (5) @(posedge clk_25_vga);
    #2;
    arst_n = 1'b1;
    step();
    // idle state out of reset
    check_direction(direction, cam_pkg::DIR_NONE);
    check_drive(drive, drive_of(cam_pkg::DRV_STOP, 2'd0));
    pixel_path_test();
    threshold_test();
    direction_test();
    min_hits_tie_test();
    manual_drive_test();
    auto_drive_test();
    repeat (4) step();
    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== all.f ====
hw/cam_pkg.sv
hw/pixel_unpack.sv
hw/target_finder.sv
hw/direction_classifier.sv
hw/drive_fsm.sv
hw/cam_track_top.sv
dv/cam_track_assertions.sv
dv/cam_track_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the cam_track testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f all.f --top-module cam_track_tb -o cam_track_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

./obj_dir/cam_track_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the log decides, the exit status alone is not enough
if grep -q "^TB PASSED$" sim.log; then
  echo "result: pass"
  exit 0
else
  echo "result: fail"
  exit 1
fi
